// File: bpi_dev_pkg.sv
package bpi_dev_pkg;

  // --------------------------------------------------
  // bus geometry
  // --------------------------------------------------
  localparam int ADR_W = 24; // word address
  localparam int DQ_W  = 16; // data bus

  typedef logic [ADR_W-1:0] adr_t;
  typedef logic [DQ_W-1:0]  dq_t;
  typedef logic [7:0]       blk_t; // word address bits 23:16

  // --------------------------------------------------
  // P30 command opcodes
  // --------------------------------------------------
  localparam dq_t OP_LOCK_SETUP  = 16'h0060;
  localparam dq_t OP_CONFIRM     = 16'h00D0; // unlock and erase confirm
  localparam dq_t OP_READ_ID     = 16'h0090;
  localparam dq_t OP_CLR_SR      = 16'h0050;
  localparam dq_t OP_ERASE_SETUP = 16'h0020;

  // status and identifier bits
  localparam dq_t SR_READY      = 16'h0080; // ready with no error flags
  localparam int  SR_BIT_READY  = 7;
  localparam int  ID_BIT_LOCKED = 0;

  // --------------------------------------------------
  // block layout, top boot part
  // --------------------------------------------------
  localparam adr_t BLK_STEP_MAIN = 24'h010000; // 64K words
  localparam adr_t BLK_STEP_TOP  = 24'h004000; // 16K words
  localparam blk_t TOP_BLK       = 8'hFF;      // first 16K-word block
  localparam adr_t LOCK_ID_OFS   = 24'h000002; // lock status in ID space

endpackage

// File: prog_cmd_pkg.sv
package prog_cmd_pkg;

  // --------------------------------------------------
  // host command word
  // --------------------------------------------------
  typedef logic [31:0] usr_word_t;

  localparam int CMD_LSB = 0; // command field, 8 bits
  localparam int ADR_LSB = 8; // address field, 24 bits

  typedef enum logic [7:0] {
    CMD_ADR_START = 8'h00, // start block from address bits 23:16
    CMD_ADR_END   = 8'h01,
    CMD_UNLOCK    = 8'h02,
    CMD_ERASE     = 8'h03
  } usr_cmd_t;

  // --------------------------------------------------
  // error codes seen by the host
  // --------------------------------------------------
  typedef enum logic [2:0] {
    ERR_NONE       = 3'd0,
    ERR_UNLOCK_TMO = 3'd1, // block stays locked
    ERR_ERASE_FAIL = 3'd2, // ready with error bits
    ERR_ERASE_TMO  = 3'd3  // never ready
  } err_t;

endpackage

// File: bpi_cmd_decode.sv
`timescale 1ns/1ns

module bpi_cmd_decode (
  input  logic                     p_in_clk,
  input  logic                     p_in_rst,
  input  prog_cmd_pkg::usr_word_t  i_usr_txd,
  input  logic                     i_usr_txrdy_n,
  output logic                     o_usr_rd,
  output logic                     o_rdy,
  input  logic                     i_busy,
  output logic                     o_op_unlock,
  output logic                     o_op_erase,
  output bpi_dev_pkg::blk_t        o_start_blk,
  output bpi_dev_pkg::blk_t        o_end_blk,
  output logic                     o_adr_set,
  output logic                     o_accept
);
  import prog_cmd_pkg::*;
  import bpi_dev_pkg::*;

  usr_cmd_t cmd;
  blk_t     adr_blk;

  assign cmd     = usr_cmd_t'(i_usr_txd[CMD_LSB +: 8]);
  assign adr_blk = i_usr_txd[ADR_LSB + ADR_W - 8 +: 8]; // address bits 23:16

  // hold off while the last word is still being acted on
  assign o_rdy    = ~(i_busy | o_op_unlock | o_op_erase | o_adr_set);
  assign o_usr_rd = o_rdy & ~i_usr_txrdy_n; // FWFT pop
  assign o_accept = o_usr_rd;

  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
    begin
      o_op_unlock <= 1'b0;
      o_op_erase  <= 1'b0;
      o_adr_set   <= 1'b0;
      o_start_blk <= '0;
      o_end_blk   <= '0;
    end
    else
    begin
      o_op_unlock <= 1'b0; // all requests are single cycle
      o_op_erase  <= 1'b0;
      o_adr_set   <= 1'b0;
      if (o_usr_rd)
      begin
        case (cmd)
          CMD_ADR_START:
          begin
            o_start_blk <= adr_blk;
            o_adr_set   <= 1'b1;
          end
          CMD_ADR_END:
          begin
            o_end_blk <= adr_blk; // only the block part is compared
            o_adr_set <= 1'b1;
          end
          CMD_UNLOCK: o_op_unlock <= 1'b1;
          CMD_ERASE:  o_op_erase  <= 1'b1;
          default:    o_adr_set   <= 1'b0; // unknown code, word dropped
        endcase
      end
    end
  end

  a_one_op : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    !(o_op_unlock && o_op_erase));

  // sequencer must be idle whenever a request reaches it
  a_op_when_idle : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    (o_op_unlock || o_op_erase) |-> !i_busy);

endmodule

// File: bpi_bus_seq.sv
`timescale 1ns/1ns

module bpi_bus_seq #(
  parameter int unsigned UNLOCK_POLL_MAX = 256,
  parameter int unsigned ERASE_POLL_MAX  = 16000000
) (
  input  logic                p_in_clk,
  input  logic                p_in_rst,
  input  logic                i_op_unlock,
  input  logic                i_op_erase,
  input  bpi_dev_pkg::blk_t   i_start_blk,
  input  bpi_dev_pkg::blk_t   i_end_blk,
  output logic                o_busy,
  output logic                o_op_done,
  output logic                o_fault,
  output prog_cmd_pkg::err_t  o_fault_code,
  output bpi_dev_pkg::adr_t   o_phy_adr,
  output bpi_dev_pkg::dq_t    o_phy_d,
  input  bpi_dev_pkg::dq_t    i_phy_d,
  output logic                o_phy_dio_t,
  output logic                o_phy_oe_n,
  output logic                o_phy_we_n,
  output logic                o_phy_cs_n
);
  import bpi_dev_pkg::*;
  import prog_cmd_pkg::*;

  localparam int UNL_W = $clog2(UNLOCK_POLL_MAX + 1);
  localparam int ERS_W = $clog2(ERASE_POLL_MAX + 1);

  typedef enum logic [2:0] {
    S_IDLE, S_WR_LO, S_WR_HI, S_RD_LO, S_RD_HI, S_FAULT
  } state_t;

  state_t           state;
  state_t           state_nx;
  logic             erase_q;    // 0 unlock, 1 erase
  logic             erase_nx;
  logic [1:0]       step;       // command word within the block sequence
  logic [1:0]       step_nx;
  adr_t             blk_adr;    // base of current block
  adr_t             blk_adr_nx;
  adr_t             blk_step;
  logic             last_blk;
  logic             blk_pass;
  logic [UNL_W-1:0] unl_cnt;
  logic [UNL_W-1:0] unl_cnt_nx;
  logic [ERS_W-1:0] ers_cnt;
  logic [ERS_W-1:0] ers_cnt_nx;
  dq_t              sr_q;       // captured status or lock id
  logic             done_nx;
  logic             fault_nx;
  err_t             code_nx;

  function automatic dq_t seq_op(input logic erase, input logic [1:0] idx);
    dq_t op;
    case ({erase, idx})
      3'b000:  op = OP_LOCK_SETUP;
      3'b001:  op = OP_CONFIRM;
      3'b010:  op = OP_READ_ID;
      3'b100:  op = OP_CLR_SR;
      3'b101:  op = OP_ERASE_SETUP;
      3'b110:  op = OP_CONFIRM;
      default: op = '0;
    endcase
    return op;
  endfunction

  // top block number holds four 16K-word blocks
  assign blk_step = (blk_adr[ADR_W-1 -: 8] == TOP_BLK) ? BLK_STEP_TOP : BLK_STEP_MAIN;
  assign last_blk = (blk_adr[ADR_W-1 -: 8] == i_end_blk) &&
                    ((blk_adr[ADR_W-1 -: 8] != TOP_BLK) ||
                     (blk_adr[15:0] == 16'(BLK_STEP_MAIN - BLK_STEP_TOP)));
  assign blk_pass = erase_q ? (sr_q == SR_READY) : !sr_q[ID_BIT_LOCKED];

  assign o_busy = (state != S_IDLE) || o_op_done; // covers the done cycle

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb
  begin
    state_nx   = state;
    erase_nx   = erase_q;
    step_nx    = step;
    blk_adr_nx = blk_adr;
    unl_cnt_nx = unl_cnt;
    ers_cnt_nx = ers_cnt;
    done_nx    = 1'b0;
    fault_nx   = 1'b0;
    code_nx    = ERR_NONE;
    case (state)
      S_IDLE:
        if (i_op_unlock || i_op_erase)
        begin
          state_nx   = S_WR_LO;
          erase_nx   = i_op_erase;
          step_nx    = '0;
          blk_adr_nx = {i_start_blk, {(ADR_W - 8){1'b0}}};
          unl_cnt_nx = '0;
          ers_cnt_nx = '0;
        end
      S_WR_LO: state_nx = S_WR_HI;
      S_WR_HI:
        if (step == 2'd2)
          state_nx = S_RD_LO;
        else
        begin
          step_nx  = step + 2'd1;
          state_nx = S_WR_LO;
        end
      S_RD_LO: state_nx = S_RD_HI;
      S_RD_HI:
        if (blk_pass)
        begin
          step_nx    = '0;
          unl_cnt_nx = '0;
          ers_cnt_nx = '0;
          if (last_blk)
          begin
            state_nx = S_IDLE;
            done_nx  = 1'b1;
          end
          else
          begin
            blk_adr_nx = blk_adr + blk_step;
            state_nx   = S_WR_LO;
          end
        end
        else if (!erase_q)
        begin
          step_nx = '0; // resend the whole unlock sequence
          if (unl_cnt == UNL_W'(UNLOCK_POLL_MAX - 1))
          begin
            state_nx = S_FAULT;
            fault_nx = 1'b1;
            code_nx  = ERR_UNLOCK_TMO;
          end
          else
          begin
            unl_cnt_nx = unl_cnt + 1'b1;
            state_nx   = S_WR_LO;
          end
        end
        else if (sr_q[SR_BIT_READY])
        begin
          state_nx = S_FAULT; // ready, but error bits set
          fault_nx = 1'b1;
          code_nx  = ERR_ERASE_FAIL;
        end
        else if (ers_cnt == ERS_W'(ERASE_POLL_MAX - 1))
        begin
          state_nx = S_FAULT;
          fault_nx = 1'b1;
          code_nx  = ERR_ERASE_TMO;
        end
        else
        begin
          ers_cnt_nx = ers_cnt + 1'b1;
          state_nx   = S_RD_LO; // poll again
        end
      S_FAULT: state_nx = S_FAULT; // held until reset
      default: state_nx = S_IDLE;
    endcase
  end

  // --------------------------------------------------
  // control registers and bus strobes
  // --------------------------------------------------
  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
    begin
      state        <= S_IDLE;
      erase_q      <= 1'b0;
      step         <= '0;
      unl_cnt      <= '0;
      ers_cnt      <= '0;
      o_op_done    <= 1'b0;
      o_fault      <= 1'b0;
      o_fault_code <= ERR_NONE;
      o_phy_we_n   <= 1'b1;
      o_phy_oe_n   <= 1'b1;
      o_phy_dio_t  <= 1'b0;
      o_phy_cs_n   <= 1'b1;
    end
    else
    begin
      state     <= state_nx;
      erase_q   <= erase_nx;
      step      <= step_nx;
      unl_cnt   <= unl_cnt_nx;
      ers_cnt   <= ers_cnt_nx;
      o_op_done <= done_nx;
      o_fault   <= fault_nx;
      if (fault_nx)
        o_fault_code <= code_nx;
      o_phy_we_n  <= (state_nx != S_WR_LO);
      o_phy_oe_n  <= (state_nx != S_RD_LO);
      o_phy_dio_t <= (state_nx == S_RD_LO) || (state_nx == S_RD_HI);
      o_phy_cs_n  <= (state_nx == S_IDLE) || (state_nx == S_FAULT);
    end
  end

  always_ff @(posedge p_in_clk)
  begin
    blk_adr   <= blk_adr_nx;
    o_phy_adr <= blk_adr_nx + (erase_nx ? '0 : LOCK_ID_OFS);
    o_phy_d   <= (state_nx == S_WR_LO || state_nx == S_WR_HI) ? seq_op(erase_nx, step_nx) : '0;
    if (state == S_RD_LO)
      sr_q <= i_phy_d; // end of oe_n low cycle
  end

  a_we_oe_excl : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    !(!o_phy_we_n && !o_phy_oe_n));

  a_read_tristate : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    !o_phy_oe_n |-> o_phy_dio_t);

  // flash latches on the rising we_n edge
  a_write_hold : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    $rose(o_phy_we_n) |-> ($stable(o_phy_d) && $stable(o_phy_adr)));

endmodule

// File: bpi_status_track.sv
`timescale 1ns/1ns

module bpi_status_track (
  input  logic                p_in_clk,
  input  logic                p_in_rst,
  input  logic                i_op_done,
  input  logic                i_adr_set,
  input  logic                i_fault,
  input  prog_cmd_pkg::err_t  i_fault_code,
  input  logic                i_accept,
  output logic [3:0]          o_status
);
  import prog_cmd_pkg::*;

  err_t err_q;  // sticky error code
  logic done_q;

  // --------------------------------------------------
  // error code
  // --------------------------------------------------
  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
      err_q <= ERR_NONE;
    else if (i_fault)
      err_q <= i_fault_code; // only reset clears it
  end

  // --------------------------------------------------
  // done flag
  // --------------------------------------------------
  always_ff @(posedge p_in_clk or posedge p_in_rst)
  begin
    if (p_in_rst)
      done_q <= 1'b0;
    else if (i_op_done || i_adr_set || i_fault)
      done_q <= 1'b1; // set wins over clear
    else if (i_accept)
      done_q <= 1'b0; // next host word
  end

  assign o_status = {done_q, err_q};

  // sequencer stalls after a fault, so a code never changes once set
  a_err_sticky : assert property (@(posedge p_in_clk) disable iff (p_in_rst)
    (err_q != ERR_NONE) |=> $stable(err_q));

endmodule

// File: bpi_prog.sv
`timescale 1ns/1ns

module bpi_prog #(
  parameter int unsigned UNLOCK_POLL_MAX = 256,
  parameter int unsigned ERASE_POLL_MAX  = 16000000
) (
  input  logic                     p_in_clk,
  input  logic                     p_in_rst,
  input  prog_cmd_pkg::usr_word_t  i_usr_txd,
  input  logic                     i_usr_txrdy_n,
  output logic                     o_usr_rd,
  output logic                     o_rdy,
  output logic [3:0]               o_status,
  output bpi_dev_pkg::adr_t        o_phy_adr,
  output bpi_dev_pkg::dq_t         o_phy_d,
  input  bpi_dev_pkg::dq_t         i_phy_d,
  output logic                     o_phy_dio_t,
  output logic                     o_phy_oe_n,
  output logic                     o_phy_we_n,
  output logic                     o_phy_cs_n
);
  import bpi_dev_pkg::*;
  import prog_cmd_pkg::*;

  logic op_unlock;
  logic op_erase;
  blk_t start_blk;
  blk_t end_blk;
  logic adr_set;
  logic accept;
  logic busy;
  logic op_done;
  logic fault;
  err_t fault_code;

  bpi_cmd_decode u_decode (
    .p_in_clk      (p_in_clk),
    .p_in_rst      (p_in_rst),
    .i_usr_txd     (i_usr_txd),
    .i_usr_txrdy_n (i_usr_txrdy_n),
    .o_usr_rd      (o_usr_rd),
    .o_rdy         (o_rdy),
    .i_busy        (busy),
    .o_op_unlock   (op_unlock),
    .o_op_erase    (op_erase),
    .o_start_blk   (start_blk),
    .o_end_blk     (end_blk),
    .o_adr_set     (adr_set),
    .o_accept      (accept)
  );

  bpi_bus_seq #(
    .UNLOCK_POLL_MAX (UNLOCK_POLL_MAX),
    .ERASE_POLL_MAX  (ERASE_POLL_MAX)
  ) u_seq (
    .p_in_clk     (p_in_clk),
    .p_in_rst     (p_in_rst),
    .i_op_unlock  (op_unlock),
    .i_op_erase   (op_erase),
    .i_start_blk  (start_blk),
    .i_end_blk    (end_blk),
    .o_busy       (busy),
    .o_op_done    (op_done),
    .o_fault      (fault),
    .o_fault_code (fault_code),
    .o_phy_adr    (o_phy_adr),
    .o_phy_d      (o_phy_d),
    .i_phy_d      (i_phy_d),
    .o_phy_dio_t  (o_phy_dio_t),
    .o_phy_oe_n   (o_phy_oe_n),
    .o_phy_we_n   (o_phy_we_n),
    .o_phy_cs_n   (o_phy_cs_n)
  );

  bpi_status_track u_status (
    .p_in_clk     (p_in_clk),
    .p_in_rst     (p_in_rst),
    .i_op_done    (op_done),
    .i_adr_set    (adr_set),
    .i_fault      (fault),
    .i_fault_code (fault_code),
    .i_accept     (accept),
    .o_status     (o_status)
  );

endmodule

// File: tb_bpi_flash_model.sv
`timescale 1ns/1ns

module tb_bpi_flash_model (
  input  bpi_dev_pkg::adr_t i_adr,
  input  bpi_dev_pkg::dq_t  i_d,
  output bpi_dev_pkg::dq_t  o_d,
  input  logic              i_oe_n,
  input  logic              i_we_n,
  input  logic              i_cs_n,
  input  logic [1:0]        i_mode
);
  import bpi_dev_pkg::*;

  localparam int         LOG_MAX          = 512;
  localparam int         ERASE_BUSY_READS = 3;
  localparam logic [1:0] MODE_LOCK_STUCK  = 2'd1;
  localparam logic [1:0] MODE_ERASE_FAIL  = 2'd2;
  localparam logic [1:0] MODE_NEVER_READY = 2'd3;
  localparam dq_t        SR_ERASE_ERR     = 16'h0020; // erase error flag, bit 5

  adr_t log_adr [LOG_MAX];
  dq_t  log_dat [LOG_MAX];
  int   log_cnt;
  logic locked [1024]; // one bit per 16K-word unit
  dq_t  last_cmd;
  logic id_mode;       // reads return lock id instead of status
  int   busy_left;
  dq_t  rd_q;

  initial
  begin
    log_cnt   = 0;
    last_cmd  = '0;
    id_mode   = 1'b0;
    busy_left = 0;
    rd_q      = '0;
    for (int i = 0; i < 1024; i++)
      locked[i] = 1'b1; // power up locked
  end

  // --------------------------------------------------
  // command writes, latched on rising we_n
  // --------------------------------------------------
  always @(posedge i_we_n)
  begin
    if (i_cs_n === 1'b0)
    begin
      if (log_cnt < LOG_MAX)
      begin
        log_adr[log_cnt] = i_adr;
        log_dat[log_cnt] = i_d;
      end
      log_cnt = log_cnt + 1;
      if (i_d == OP_CONFIRM && last_cmd == OP_LOCK_SETUP && i_mode != MODE_LOCK_STUCK)
        locked[i_adr[ADR_W-1:14]] = 1'b0;
      if (i_d == OP_CONFIRM && last_cmd == OP_ERASE_SETUP)
        busy_left = ERASE_BUSY_READS; // erase starts
      if (i_d == OP_READ_ID)
        id_mode = 1'b1;
      else if (i_d == OP_CLR_SR || i_d == OP_ERASE_SETUP)
        id_mode = 1'b0;
      last_cmd = i_d;
    end
  end

  // --------------------------------------------------
  // read answers
  // --------------------------------------------------
  always @(negedge i_oe_n)
  begin
    #1; // answer once the address is stable
    if (id_mode)
    begin
      rd_q = '0;
      rd_q[ID_BIT_LOCKED] = locked[i_adr[ADR_W-1:14]] | (i_mode == MODE_LOCK_STUCK);
    end
    else if (i_mode == MODE_ERASE_FAIL)
      rd_q = SR_READY | SR_ERASE_ERR;
    else if (i_mode == MODE_NEVER_READY)
      rd_q = '0;
    else if (busy_left > 0)
    begin
      rd_q      = '0; // still erasing
      busy_left = busy_left - 1;
    end
    else
      rd_q = SR_READY;
  end

  assign o_d = i_oe_n ? '0 : rd_q;

endmodule

// File: tb_bpi_prog.sv
`timescale 1ns/1ns

module tb_bpi_prog;
  import bpi_dev_pkg::*;
  import prog_cmd_pkg::*;

  localparam int         CLK_HALF         = 4;
  localparam int         POP_TMO          = 50;
  localparam int         OP_TMO           = 5000;
  localparam int         N_ROWS           = 8;
  localparam logic [1:0] MODE_NORMAL      = 2'd0;
  localparam logic [1:0] MODE_LOCK_STUCK  = 2'd1;
  localparam logic [1:0] MODE_ERASE_FAIL  = 2'd2;
  localparam logic [1:0] MODE_NEVER_READY = 2'd3;

  typedef struct {
    blk_t       start_blk;
    adr_t       end_adr;
    logic [7:0] op;
    logic [1:0] mode;
    err_t       exp_err;
    int         exp_nblk;
  } row_t;

  row_t      rows [N_ROWS];
  logic      p_in_clk;
  logic      p_in_rst;
  usr_word_t usr_txd;
  logic      usr_txrdy_n;
  logic      usr_rd;
  logic      rdy;
  logic [3:0] status;
  adr_t      phy_adr;
  dq_t       phy_d_out;
  dq_t       phy_d_in;
  logic      phy_dio_t;
  logic      phy_oe_n;
  logic      phy_we_n;
  logic      phy_cs_n;
  logic [1:0] flash_mode;
  int        err_cnt = 0;
  int        chk_cnt = 0;
  int        tmo_cnt = 0;
  int        pop_cnt = 0;

  bpi_prog #(
    .UNLOCK_POLL_MAX (8),
    .ERASE_POLL_MAX  (20)
  ) u_bpi_prog (
    .p_in_clk      (p_in_clk),
    .p_in_rst      (p_in_rst),
    .i_usr_txd     (usr_txd),
    .i_usr_txrdy_n (usr_txrdy_n),
    .o_usr_rd      (usr_rd),
    .o_rdy         (rdy),
    .o_status      (status),
    .o_phy_adr     (phy_adr),
    .o_phy_d       (phy_d_out),
    .i_phy_d       (phy_d_in),
    .o_phy_dio_t   (phy_dio_t),
    .o_phy_oe_n    (phy_oe_n),
    .o_phy_we_n    (phy_we_n),
    .o_phy_cs_n    (phy_cs_n)
  );

  tb_bpi_flash_model u_flash (
    .i_adr  (phy_adr),
    .i_d    (phy_d_out),
    .o_d    (phy_d_in),
    .i_oe_n (phy_oe_n),
    .i_we_n (phy_we_n),
    .i_cs_n (phy_cs_n),
    .i_mode (flash_mode)
  );

  initial
  begin
    p_in_clk = 1'b0;
    forever #CLK_HALF p_in_clk = ~p_in_clk;
  end

  always @(negedge p_in_clk)
  begin
    if (usr_rd)
      pop_cnt = pop_cnt + 1; // pop happens at the next rising edge
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_err(input err_t got, input err_t exp, input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s error code %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_blk(input blk_t got, input blk_t exp, input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s block %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_adr(input adr_t got, input adr_t exp, input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dq(input dq_t got, input dq_t exp, input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    chk_cnt++;
    if (got != exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // host side
  // --------------------------------------------------
  function automatic usr_word_t make_word(input adr_t adr, input logic [7:0] cmd);
    usr_word_t w;
    w                   = '0;
    w[ADR_LSB +: ADR_W] = adr;
    w[CMD_LSB +: 8]     = cmd;
    return w;
  endfunction

  task automatic reset_dut();
    usr_txrdy_n = 1'b1;
    p_in_rst    = 1'b1;
    repeat (8) @(posedge p_in_clk);
    #1;
    p_in_rst = 1'b0;
  endtask

  task automatic push_word(input usr_word_t w);
    logic popped;
    popped      = 1'b0;
    usr_txd     = w;
    usr_txrdy_n = 1'b0;
    for (int t = 0; t < POP_TMO && !popped; t++)
    begin
      @(negedge p_in_clk);
      popped = usr_rd;
      @(posedge p_in_clk);
      #1;
    end
    usr_txrdy_n = 1'b1;
    if (!popped)
    begin
      tmo_cnt++;
      $display("timeout: host word %h was not popped within %0d cycles", w, POP_TMO);
    end
    else
    begin
      @(negedge p_in_clk);
      check_flag(status[3], 1'b0, "done after accepted word"); // cleared by the pop
      @(posedge p_in_clk);
      #1;
    end
  endtask

  task automatic wait_end(input string what);
    logic seen;
    seen = 1'b0;
    for (int t = 0; t < OP_TMO && !seen; t++)
    begin
      @(negedge p_in_clk);
      seen = status[3] || (status[2:0] != 3'd0);
    end
    @(posedge p_in_clk);
    #1;
    if (!seen)
    begin
      tmo_cnt++;
      $display("timeout: %s did not finish within %0d cycles", what, OP_TMO);
    end
  endtask

  // watch a few cycles after an unknown code
  task automatic watch_unknown();
    logic done_seen;
    logic cs_seen;
    done_seen = 1'b0;
    cs_seen   = 1'b0;
    repeat (10)
    begin
      @(negedge p_in_clk);
      done_seen = done_seen | status[3];
      cs_seen   = cs_seen | !phy_cs_n;
    end
    @(posedge p_in_clk);
    #1;
    check_flag(done_seen, 1'b0, "done after unknown command");
    check_flag(cs_seen, 1'b0, "flash select for unknown command");
  endtask

  task automatic offer_after_fault();
    logic seen;
    seen        = 1'b0;
    usr_txd     = make_word('0, CMD_ADR_START);
    usr_txrdy_n = 1'b0;
    repeat (10)
    begin
      @(negedge p_in_clk);
      seen = seen | usr_rd;
    end
    @(posedge p_in_clk);
    #1;
    usr_txrdy_n = 1'b1;
    check_flag(seen, 1'b0, "host pop after fault");
  endtask

  // --------------------------------------------------
  // write log against the block walk
  // --------------------------------------------------
  task automatic walk_log(input int base, input row_t r);
    adr_t adr;
    adr_t ofs;
    dq_t  ops [3];
    int   idx;
    if (r.op == CMD_UNLOCK)
    begin
      ops = '{OP_LOCK_SETUP, OP_CONFIRM, OP_READ_ID};
      ofs = LOCK_ID_OFS;
    end
    else
    begin
      ops = '{OP_CLR_SR, OP_ERASE_SETUP, OP_CONFIRM};
      ofs = '0;
    end
    adr = {r.start_blk, 16'h0000};
    for (int b = 0; b < r.exp_nblk; b++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        idx = base + 3 * b + k;
        check_adr(u_flash.log_adr[idx], adr + ofs, "write address");
        check_dq(u_flash.log_dat[idx], ops[k], "write data");
      end
      if (b == r.exp_nblk - 1)
        check_blk(u_flash.log_adr[idx][ADR_W-1 -: 8], r.end_adr[ADR_W-1 -: 8],
                  "final block");
      // 16K-word blocks from 0xFF0000 up
      adr = adr + ((adr >= {TOP_BLK, 16'h0000}) ? BLK_STEP_TOP : BLK_STEP_MAIN);
    end
  endtask

  task automatic run_row(input int i);
    row_t r;
    int   p0;
    int   base;
    int   n;
    logic is_op;
    r     = rows[i];
    is_op = (r.op == CMD_UNLOCK) || (r.op == CMD_ERASE);
    if (r.exp_err != ERR_NONE)
      reset_dut(); // faults stick until reset
    flash_mode = r.mode;
    p0         = pop_cnt;
    push_word(make_word({r.start_blk, 16'h0000}, CMD_ADR_START));
    wait_end("set start");
    check_flag(status[3], 1'b1, "done after set start");
    check_err(err_t'(status[2:0]), ERR_NONE, "set start");
    push_word(make_word(r.end_adr, CMD_ADR_END));
    wait_end("set end");
    check_flag(status[3], 1'b1, "done after set end");
    check_err(err_t'(status[2:0]), ERR_NONE, "set end");
    check_count(pop_cnt - p0, 2, "pops for address commands");
    base = u_flash.log_cnt;
    push_word(make_word('0, r.op));
    if (is_op)
    begin
      wait_end("block operation");
      check_flag(status[3], 1'b1, "done after operation");
      check_err(err_t'(status[2:0]), r.exp_err, "operation");
    end
    else
      watch_unknown();
    n = u_flash.log_cnt - base;
    if (r.exp_err == ERR_NONE)
      check_count(n, 3 * r.exp_nblk, "flash writes");
    if (n >= 3 * r.exp_nblk)
      walk_log(base, r);
    check_flag(phy_cs_n, 1'b1, "cs_n at end of row");
    if (r.exp_err == ERR_ERASE_FAIL)
      offer_after_fault();
  endtask

  task automatic load_table();
    rows[0] = '{8'h10, 24'h123456, CMD_UNLOCK, MODE_NORMAL, ERR_NONE, 3};
    rows[1] = '{8'h10, 24'h123456, CMD_ERASE, MODE_NORMAL, ERR_NONE, 3};
    rows[2] = '{8'hFE, 24'hFF0000, CMD_UNLOCK, MODE_NORMAL, ERR_NONE, 5};
    rows[3] = '{8'hFE, 24'hFFC123, CMD_ERASE, MODE_NORMAL, ERR_NONE, 5};
    rows[4] = '{8'h33, 24'h340000, 8'h04, MODE_NORMAL, ERR_NONE, 0}; // old write code
    rows[5] = '{8'h20, 24'h200000, CMD_ERASE, MODE_ERASE_FAIL, ERR_ERASE_FAIL, 1};
    rows[6] = '{8'h30, 24'h30FFFF, CMD_ERASE, MODE_NEVER_READY, ERR_ERASE_TMO, 1};
    rows[7] = '{8'h40, 24'h400000, CMD_UNLOCK, MODE_LOCK_STUCK, ERR_UNLOCK_TMO, 1};
  endtask

  initial
  begin
    p_in_rst    = 1'b1;
    usr_txd     = '0;
    usr_txrdy_n = 1'b1;
    flash_mode  = MODE_NORMAL;
    load_table();
    reset_dut();
    @(negedge p_in_clk);
    check_flag(rdy, 1'b1, "o_rdy after reset");
    check_flag(usr_rd, 1'b0, "o_usr_rd after reset");
    check_count(int'(status), 0, "status after reset");
    check_flag(phy_cs_n & phy_we_n & phy_oe_n, 1'b1, "flash strobes after reset");
    check_flag(phy_dio_t, 1'b0, "dio_t after reset");
    @(posedge p_in_clk);
    #1;
    for (int i = 0; i < N_ROWS; i++)
      run_row(i);
    $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: bpi_prog.f
bpi_dev_pkg.sv
prog_cmd_pkg.sv
bpi_cmd_decode.sv
bpi_bus_seq.sv
bpi_status_track.sv
bpi_prog.sv
tb_bpi_flash_model.sv
tb_bpi_prog.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bpi_prog
RTL_TOP   ?= bpi_prog
FLIST     ?= bpi_prog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

SRC     := $(shell cat $(FLIST))
RTL_SRC := $(filter-out tb_%,$(SRC))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRC)

$(BIN): $(SRC) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
